/* design/rv32i_params.svh */
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_ALU_OP_W    3
`define RV_RESET_PC    32'h0000_0000

// ##################################################
// Opcodes, inst[6:0]
`define RV_OP_R        7'b0110011
`define RV_OP_I_ARITH  7'b0010011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LUI      7'b0110111

`define RV_ALU_ADD     3'd0
`define RV_ALU_SUB     3'd1
`define RV_ALU_AND     3'd2
`define RV_ALU_OR      3'd3
`define RV_ALU_XOR     3'd4
`define RV_ALU_SLL     3'd5

`define RV_F3_BEQ      3'b000
`define RV_F3_BLT      3'b100
`define RV_F3_BGEU     3'b111

`endif

/* design/rv32i_pkg.sv */
`default_nettype none

`include "rv32i_params.svh"

package rv32i_pkg;

  typedef logic [`RV_XLEN-1:0]       word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`RV_ALU_OP_W-1:0]   alu_op_t;

  // Decoded control word
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src_imm;  // Second ALU operand is the immediate
    logic    zero_src1;    // First ALU operand forced to zero, lui
    logic    branch;
    alu_op_t alu_op;
  } ctrl_t;

  // ##################################################
  // Pipeline registers
  typedef struct packed {
    ctrl_t       ctrl;
    word_t       pc;
    word_t       rs1_data;  // Already forwarded in decode
    word_t       rs2_data;
    word_t       imm;
    reg_addr_t   rd;
    logic [2:0]  funct3;    // Branch condition select
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    word_t     alu_out;
    word_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    word_t     alu_out;
    word_t     load_data;
    reg_addr_t rd;
  } mem_wb_t;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_params.svh"

module alu (
  input  rv32i_pkg::word_t  a,
  input  rv32i_pkg::word_t  b,
  input  rv32i_pkg::alu_op_t alu_op,
  output rv32i_pkg::word_t  result,
  output logic              n,
  output logic              z,
  output logic              c,
  output logic              v
);

  logic             sub;
  rv32i_pkg::word_t b_eff;
  rv32i_pkg::word_t sum;

  // One adder for add and sub
  assign sub          = (alu_op == `RV_ALU_SUB);
  assign b_eff        = sub ? ~b : b;
  assign {c, sum}     = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub};

  always_comb
  begin
    case (alu_op)
      `RV_ALU_AND: result = a & b;
      `RV_ALU_OR:  result = a | b;
      `RV_ALU_XOR: result = a ^ b;
      `RV_ALU_SLL: result = a << b[4:0];
      default:     result = sum;  // add, sub
    endcase
  end

  assign n = result[`RV_XLEN-1];
  assign z = (result == '0);
  assign v = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) && (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_params.svh"

module regfile (
  input  wire                   clk,
  input  wire                   reset,
  input  rv32i_pkg::reg_addr_t  rs1,
  input  rv32i_pkg::reg_addr_t  rs2,
  input  rv32i_pkg::reg_addr_t  rd,
  input  wire                   we,
  input  rv32i_pkg::word_t      rd_data,
  output rv32i_pkg::word_t      rs1_data,
  output rv32i_pkg::word_t      rs2_data
);

  rv32i_pkg::word_t regs [(1 << `RV_REG_ADDR_W)];

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < (1 << `RV_REG_ADDR_W); i++)
        regs[i] <= '0;
    end
    else if (we && rd != '0)  // x0 never written
      regs[rd] <= rd_data;
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("regfile: x0 read back nonzero");

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
  input  rv32i_pkg::reg_addr_t id_rs1,
  input  rv32i_pkg::reg_addr_t id_rs2,
  input  rv32i_pkg::reg_addr_t ex_rd,
  input  wire                  ex_reg_write,
  input  wire                  ex_mem_read,
  input  rv32i_pkg::word_t     ex_alu_out,
  input  rv32i_pkg::reg_addr_t mem_rd,
  input  wire                  mem_reg_write,
  input  wire                  mem_mem_read,
  input  rv32i_pkg::word_t     mem_alu_out,
  input  rv32i_pkg::word_t     mem_rdata,
  input  rv32i_pkg::reg_addr_t wb_rd,
  input  wire                  wb_reg_write,
  input  rv32i_pkg::word_t     wb_data,
  input  rv32i_pkg::word_t     rf_rs1,
  input  rv32i_pkg::word_t     rf_rs2,
  output rv32i_pkg::word_t     fwd_rs1,
  output rv32i_pkg::word_t     fwd_rs2,
  output logic                 stall
);

  // Youngest producer wins
  function automatic rv32i_pkg::word_t fwd_sel(input rv32i_pkg::reg_addr_t src,
                                               input rv32i_pkg::word_t rf_val);
    rv32i_pkg::word_t val;
    val = rf_val;
    if (src != '0)
    begin
      if (ex_reg_write && !ex_mem_read && ex_rd == src)
        val = ex_alu_out;                 // Live execute result
      else if (mem_reg_write && mem_mem_read && mem_rd == src)
        val = mem_rdata;                  // Load returning this cycle
      else if (mem_reg_write && mem_rd == src)
        val = mem_alu_out;
      else if (wb_reg_write && wb_rd == src)
        val = wb_data;                    // Same-cycle regfile write
    end
    return val;
  endfunction

  always_comb
  begin
    fwd_rs1 = fwd_sel(id_rs1, rf_rs1);
    fwd_rs2 = fwd_sel(id_rs2, rf_rs2);
  end

  // Load data is not ready until the memory stage
  assign stall = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_params.svh"

module decoder (
  input  rv32i_pkg::word_t id_inst,
  output rv32i_pkg::ctrl_t id_ctrl,
  output rv32i_pkg::word_t id_imm
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv32i_pkg::word_t imm_i;
  rv32i_pkg::word_t imm_s;
  rv32i_pkg::word_t imm_b;
  rv32i_pkg::word_t imm_u;

  assign opcode = id_inst[6:0];
  assign funct3 = id_inst[14:12];
  assign funct7 = id_inst[31:25];

  // Sign-extended immediates, one per format
  assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
  assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                  id_inst[11:8], 1'b0};
  assign imm_u = {id_inst[31:12], 12'b0};

  always_comb
  begin
    id_ctrl = '0;  // Unknown opcode turns into a bubble
    case (opcode)
      `RV_OP_R:
      begin
        id_ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0100000_000: id_ctrl.alu_op = `RV_ALU_SUB;
          10'b0000000_111: id_ctrl.alu_op = `RV_ALU_AND;
          10'b0000000_110: id_ctrl.alu_op = `RV_ALU_OR;
          default:         id_ctrl.alu_op = `RV_ALU_ADD;
        endcase
      end
      `RV_OP_I_ARITH:
      begin
        id_ctrl.reg_write   = 1'b1;
        id_ctrl.alu_src_imm = 1'b1;
        case (funct3)
          3'b001:  id_ctrl.alu_op = `RV_ALU_SLL;  // slli
          3'b100:  id_ctrl.alu_op = `RV_ALU_XOR;
          3'b110:  id_ctrl.alu_op = `RV_ALU_OR;
          3'b111:  id_ctrl.alu_op = `RV_ALU_AND;
          default: id_ctrl.alu_op = `RV_ALU_ADD;
        endcase
      end
      `RV_OP_LOAD:
      begin
        id_ctrl.reg_write   = 1'b1;
        id_ctrl.mem_read    = 1'b1;
        id_ctrl.mem_to_reg  = 1'b1;
        id_ctrl.alu_src_imm = 1'b1;
      end
      `RV_OP_STORE:
      begin
        id_ctrl.mem_write   = 1'b1;
        id_ctrl.alu_src_imm = 1'b1;
      end
      `RV_OP_BRANCH:
      begin
        id_ctrl.branch = 1'b1;
        id_ctrl.alu_op = `RV_ALU_SUB;  // Flags from rs1 - rs2
      end
      `RV_OP_LUI:
      begin
        id_ctrl.reg_write   = 1'b1;
        id_ctrl.alu_src_imm = 1'b1;
        id_ctrl.zero_src1   = 1'b1;  // 0 + imm_u
      end
      default:
      begin
        id_ctrl = '0;
      end
    endcase
  end

  always_comb
  begin
    case (opcode)
      `RV_OP_STORE:  id_imm = imm_s;
      `RV_OP_BRANCH: id_imm = imm_b;
      `RV_OP_LUI:    id_imm = imm_u;
      default:       id_imm = imm_i;
    endcase
  end

  // Only add/sub/and/or encodings expected on R-type
  always_comb
  begin
    if (opcode == `RV_OP_R)
      assert (funct7 == 7'b0000000 || funct7 == 7'b0100000)
        else $error("decoder: unsupported R-type funct7 %b", funct7);
  end

endmodule

`default_nettype wire

/* design/pipeline_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_params.svh"

module pipeline_datapath (
  input  wire                  clk,
  input  wire                  reset,
  output rv32i_pkg::word_t     pc,
  input  rv32i_pkg::word_t     inst,
  output rv32i_pkg::word_t     id_inst,
  input  rv32i_pkg::ctrl_t     id_ctrl,
  input  rv32i_pkg::word_t     id_imm,
  output rv32i_pkg::dmem_req_t dmem_req,
  input  rv32i_pkg::word_t     mem_rdata
);

  rv32i_pkg::word_t     if_id_inst;
  rv32i_pkg::word_t     if_id_pc;
  rv32i_pkg::id_ex_t    id_ex;
  rv32i_pkg::ex_mem_t   ex_mem;
  rv32i_pkg::mem_wb_t   mem_wb;
  rv32i_pkg::reg_addr_t id_rs1;
  rv32i_pkg::reg_addr_t id_rs2;
  rv32i_pkg::word_t     rf_rs1;
  rv32i_pkg::word_t     rf_rs2;
  rv32i_pkg::word_t     fwd_rs1;
  rv32i_pkg::word_t     fwd_rs2;
  logic                 stall;
  rv32i_pkg::word_t     alu_a;
  rv32i_pkg::word_t     alu_b;
  rv32i_pkg::word_t     alu_out;
  logic                 flag_n;
  logic                 flag_z;
  logic                 flag_c;
  logic                 flag_v;
  logic                 br_taken;
  rv32i_pkg::word_t     br_target;
  rv32i_pkg::word_t     wb_data;

  // ##################################################
  // Fetch
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      pc <= `RV_RESET_PC;
    else if (br_taken)
      pc <= br_target;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      if_id_inst <= '0;
      if_id_pc   <= '0;
    end
    else if (br_taken)  // Flush wins over stall
    begin
      if_id_inst <= '0;
      if_id_pc   <= '0;
    end
    else if (!stall)
    begin
      if_id_inst <= inst;
      if_id_pc   <= pc;
    end
  end

  // ##################################################
  // Decode
  assign id_inst = if_id_inst;
  assign id_rs1  = if_id_inst[19:15];
  assign id_rs2  = if_id_inst[24:20];

  regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (id_rs1),
    .rs2      (id_rs2),
    .rd       (mem_wb.rd),
    .we       (mem_wb.reg_write),
    .rd_data  (wb_data),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

  hazard_unit u_hazard (
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .ex_rd         (id_ex.rd),
    .ex_reg_write  (id_ex.ctrl.reg_write),
    .ex_mem_read   (id_ex.ctrl.mem_read),
    .ex_alu_out    (alu_out),
    .mem_rd        (ex_mem.rd),
    .mem_reg_write (ex_mem.reg_write),
    .mem_mem_read  (ex_mem.mem_read),
    .mem_alu_out   (ex_mem.alu_out),
    .mem_rdata     (mem_rdata),
    .wb_rd         (mem_wb.rd),
    .wb_reg_write  (mem_wb.reg_write),
    .wb_data       (wb_data),
    .rf_rs1        (rf_rs1),
    .rf_rs2        (rf_rs2),
    .fwd_rs1       (fwd_rs1),
    .fwd_rs2       (fwd_rs2),
    .stall         (stall)
  );

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else if (br_taken || stall)
      id_ex <= '0;  // Bubble
    else
    begin
      id_ex.ctrl     <= id_ctrl;
      id_ex.pc       <= if_id_pc;
      id_ex.rs1_data <= fwd_rs1;
      id_ex.rs2_data <= fwd_rs2;
      id_ex.imm      <= id_imm;
      id_ex.rd       <= if_id_inst[11:7];
      id_ex.funct3   <= if_id_inst[14:12];
    end
  end

  // ##################################################
  // Execute
  assign alu_a = id_ex.ctrl.zero_src1 ? '0 : id_ex.rs1_data;
  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_data;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (id_ex.ctrl.alu_op),
    .result (alu_out),
    .n      (flag_n),
    .z      (flag_z),
    .c      (flag_c),
    .v      (flag_v)
  );

  always_comb
  begin
    br_taken = 1'b0;
    if (id_ex.ctrl.branch)
    begin
      case (id_ex.funct3)
        `RV_F3_BEQ:  br_taken = flag_z;
        `RV_F3_BLT:  br_taken = flag_n ^ flag_v;  // Signed less than
        `RV_F3_BGEU: br_taken = flag_c;           // No borrow
        default:     br_taken = 1'b0;
      endcase
    end
  end

  assign br_target = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.alu_out    <= alu_out;
      ex_mem.store_data <= id_ex.rs2_data;
      ex_mem.rd         <= id_ex.rd;
    end
  end

  // ##################################################
  // Memory and write-back
  assign dmem_req.write = ex_mem.mem_write;
  assign dmem_req.addr  = ex_mem.alu_out;
  assign dmem_req.wdata = ex_mem.store_data;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
    begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.alu_out    <= ex_mem.alu_out;
      mem_wb.load_data  <= mem_rdata;
      mem_wb.rd         <= ex_mem.rd;
    end
  end

  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

  // A load in execute and a branch in execute exclude each other
  a_stall_flush: assert property (@(posedge clk) disable iff (reset)
    !(stall && br_taken))
    else $error("datapath: stall and branch flush in the same cycle");

endmodule

`default_nettype wire

/* design/rv32i_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv32i_cpu (
  input  wire                  clk,
  input  wire                  reset,
  output rv32i_pkg::word_t     pc,        // Fetch address
  input  rv32i_pkg::word_t     inst,      // Instruction at pc, same cycle
  output rv32i_pkg::dmem_req_t dmem_req,
  input  rv32i_pkg::word_t     mem_rdata  // Read data at dmem_req.addr
);

  rv32i_pkg::word_t id_inst;
  rv32i_pkg::ctrl_t id_ctrl;
  rv32i_pkg::word_t id_imm;

  // Control decode for the instruction sitting in IF/ID
  decoder u_decoder (
    .id_inst (id_inst),
    .id_ctrl (id_ctrl),
    .id_imm  (id_imm)
  );

  pipeline_datapath u_datapath (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .id_inst   (id_inst),
    .id_ctrl   (id_ctrl),
    .id_imm    (id_imm),
    .dmem_req  (dmem_req),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* test/tb_rv32i_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv32i_cpu;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 20;   // Idle time after the last store
  localparam int IMEM_AW      = 6;
  localparam int DMEM_AW      = 8;
  localparam int IMEM_WORDS   = 1 << IMEM_AW;
  localparam int DMEM_WORDS   = 1 << DMEM_AW;
  localparam int STORE_MAX    = 64;

  logic                 clk;
  logic                 reset;
  rv32i_pkg::word_t     pc;
  rv32i_pkg::word_t     inst;
  rv32i_pkg::dmem_req_t dmem_req;
  rv32i_pkg::word_t     mem_rdata;

  rv32i_pkg::word_t imem [IMEM_WORDS];
  rv32i_pkg::word_t dmem [DMEM_WORDS];
  rv32i_pkg::word_t exp_addr [STORE_MAX];
  rv32i_pkg::word_t exp_data [STORE_MAX];
  int               num_insts;
  int               num_stores;
  int               store_idx;
  logic             loaded;

  rv32i_cpu DUT (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .dmem_req  (dmem_req),
    .mem_rdata (mem_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ##################################################
  // Single-cycle memory models that are always ready
  assign inst      = imem[pc[IMEM_AW+1:2]];
  assign mem_rdata = dmem[dmem_req.addr[DMEM_AW+1:2]];

  always @(posedge clk)
  begin
    if (!reset && dmem_req.write)
      dmem[dmem_req.addr[DMEM_AW+1:2]] <= dmem_req.wdata;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_store_addr(input rv32i_pkg::word_t actual,
                                  input rv32i_pkg::word_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED at %0t: store %0d address %h, expected %h",
                                  $time, store_idx, actual, expected));
  endtask

  task automatic check_store_data(input rv32i_pkg::word_t actual,
                                  input rv32i_pkg::word_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED at %0t: store %0d data %h, expected %h",
                                  $time, store_idx, actual, expected));
  endtask

  task automatic check_pc(input rv32i_pkg::word_t actual,
                          input rv32i_pkg::word_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED at %0t: pc %h, expected %h",
                                  $time, actual, expected));
  endtask

  // ##################################################
  // Stimulus file with one record per line
  task automatic load_stimulus();
    int               fd;
    int               n;
    string            line;
    byte              kind;
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = {25'(i), 7'b0000000};  // Opcode zero decodes as a bubble
    for (int i = 0; i < DMEM_WORDS; i++)
      dmem[i] = {16'hd00d, 16'(i * 4)};
    fd = $fopen("test/program_input.txt", "r");
    if (fd == 0)
      stop_with_failure("Could not open the stimulus file test/program_input.txt");
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1)
      begin
        kind = line.getc(0);
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        case (kind)
          "I":
          begin
            if (n < 1 || num_insts >= IMEM_WORDS)
              stop_with_failure("Instruction record is malformed or does not fit");
            imem[num_insts] = a;
            num_insts++;
          end
          "D":
          begin
            if (n != 2)
              stop_with_failure("Data record needs an address and a word");
            dmem[a[DMEM_AW+1:2]] = b;
          end
          "S":
          begin
            if (n != 2 || num_stores >= STORE_MAX)
              stop_with_failure("Store record is malformed or there are too many");
            exp_addr[num_stores] = a;
            exp_data[num_stores] = b;
            num_stores++;
          end
          default:
          begin
            // Comment lines
          end
        endcase
      end
    end
    $fclose(fd);
    if (num_insts == 0 || num_stores == 0)
      stop_with_failure("Stimulus file holds no program or no expected stores");
  endtask

  // Stores are stable mid-cycle and come at most one per cycle
  always @(negedge clk)
  begin
    if (!reset && dmem_req.write)
    begin
      if (store_idx >= num_stores)
        stop_with_failure($sformatf("Unexpected store at %0t to address %h with data %h",
                                    $time, dmem_req.addr, dmem_req.wdata));
      else
      begin
        check_store_addr(dmem_req.addr, exp_addr[store_idx]);
        check_store_data(dmem_req.wdata, exp_data[store_idx]);
        store_idx = store_idx + 1;
      end
    end
  end

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    num_insts  = 0;
    num_stores = 0;
    store_idx  = 0;
    loaded     = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    check_pc(pc, 32'h0000_0000);  // Reset vector
    reset = 1'b0;
    @(negedge clk);
    check_pc(pc, 32'h0000_0004);  // One fetch later
    wait (store_idx == num_stores);
    repeat (DRAIN_CYCLES) @(negedge clk);  // Skipped stores must stay away
    $display("All %0d expected stores matched", num_stores);
    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog scaled by program length
  initial
  begin
    int limit;
    wait (loaded);
    limit = num_insts * 8 + 100;
    repeat (limit) @(posedge clk);
    stop_with_failure($sformatf("Watchdog expired: only %0d of %0d expected stores appeared",
                                store_idx, num_stores));
  end

endmodule

`default_nettype wire

/* rv32i_cpu.f */
+incdir+design
design/rv32i_pkg.sv
design/alu.sv
design/regfile.sv
design/hazard_unit.sv
design/decoder.sv
design/pipeline_datapath.sv
design/rv32i_cpu.sv
test/tb_rv32i_cpu.sv

/* Makefile */
# Verilator build and run of the RV32I pipeline testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rv32i_cpu
FILELIST  ?= rv32i_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# The run passes only when the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/program_input.txt */
# Columns: kind then hex fields. I <instruction word>, D <address> <data word>
# I lines load from address 0 in order, S <address> <data> lists expected stores in order
I 10000513  # addi x10, x0, 256
I 0F000093  # addi x1, x0, 240
I FFD00113  # addi x2, x0, -3
I 002081B3  # add  x3, x1, x2
I 40208233  # sub  x4, x1, x2
I 0041F2B3  # and  x5, x3, x4
I 0041E333  # or   x6, x3, x4
I 00652023  # sw   x6, 0(x10)
I 00552223  # sw   x5, 4(x10)
I 00452423  # sw   x4, 8(x10)
I 00352623  # sw   x3, 12(x10)
I 0FF0C393  # xori x7, x1, 0xff
I 7003E413  # ori  x8, x7, 0x700
I 03C47493  # andi x9, x8, 0x3c
I 00449593  # slli x11, x9, 4
I 12345637  # lui  x12, 0x12345
I 00752823  # sw   x7, 16(x10)
I 00852A23  # sw   x8, 20(x10)
I 00952C23  # sw   x9, 24(x10)
I 00B52E23  # sw   x11, 28(x10)
I 02C52023  # sw   x12, 32(x10)
I 04052683  # lw   x13, 64(x10)
I 00168713  # addi x14, x13, 1
I 02E52223  # sw   x14, 36(x10)
I 04452783  # lw   x15, 68(x10)
I 02F52423  # sw   x15, 40(x10)
I 00318463  # beq  x3, x3, +8 taken
I 08152023  # sw   x1, 128(x10) skipped
I 00114463  # blt  x2, x1, +8 taken
I 08252223  # sw   x2, 132(x10) skipped
I 00117463  # bgeu x2, x1, +8 taken
I 08352423  # sw   x3, 136(x10) skipped
I 00208C63  # beq  x1, x2, +24 not taken
I 0020CA63  # blt  x1, x2, +20 not taken
I 0020F863  # bgeu x1, x2, +16 not taken
I 00700013  # addi x0, x0, 7
I 02052623  # sw   x0, 44(x10)
I 00000063  # beq  x0, x0, 0 end loop
I 08152623  # sw   x1, 140(x10) never reached
D 00000140 0000ABCD
D 00000144 80000001
S 00000100 000000FF
S 00000104 000000E1
S 00000108 000000F3
S 0000010C 000000ED
S 00000110 0000000F
S 00000114 0000070F
S 00000118 0000000C
S 0000011C 000000C0
S 00000120 12345000
S 00000124 0000ABCE
S 00000128 80000001
S 0000012C 00000000
